/* verilog/video_timing_pkg.sv */
// Raster timing defaults
// Geometry of the reduced test raster and the position counter width
`default_nettype none

package video_timing_pkg;

    // Horizontal geometry in pixel slots
    localparam int H_ACTIVE = 32;
    localparam int H_TOTAL  = 48;
    localparam int HS_START = 36;
    localparam int HS_END   = 40;

    // Vertical geometry in lines
    localparam int V_ACTIVE = 16;
    localparam int V_TOTAL  = 24;
    localparam int VS_START = 18;
    localparam int VS_END   = 20;

    // Width of hdump, vdump and vrender
    localparam int POS_W = 9;

endpackage

`default_nettype wire

/* verilog/video_regs_pkg.sv */
// Video register map
// CPU port widths, register addresses, colour formats and graphics ROM sizes
`default_nettype none

package video_regs_pkg;

    // CPU write port
    localparam int REG_ADDR_W = 5;
    localparam int REG_DATA_W = 16;

    // Register addresses
    localparam logic [REG_ADDR_W-1:0] REG_HSCROLL  = 5'd0;
    localparam logic [REG_ADDR_W-1:0] REG_VSCROLL  = 5'd1;
    localparam logic [REG_ADDR_W-1:0] REG_CTRL     = 5'd2;
    localparam logic [REG_ADDR_W-1:0] REG_BACKDROP = 5'd3;
    localparam logic [REG_ADDR_W-1:0] PAL_BASE     = 5'd16;

    // Layer enable bit in REG_CTRL, bit 15 is reserved
    localparam int CTRL_LAYER_EN = 0;

    // Colour index and 4:4:4 palette entry, red in the top nibble
    localparam int PXL_W   = 4;
    localparam int COLOR_W = 12;
    localparam int CH_W    = 4;

    // Graphics ROM, 8 pixels per word
    localparam int ROM_ADDR_W = 9;
    localparam int ROM_DATA_W = 32;

endpackage

`default_nettype wire

/* verilog/video_timing.sv */
// Raster timing generator
// Pixel and line counters with sync, blanking and a one-line look-ahead
`timescale 1ns/1ns
`default_nettype none

module video_timing #(
    parameter int H_ACTIVE = video_timing_pkg::H_ACTIVE,
    parameter int H_TOTAL  = video_timing_pkg::H_TOTAL,
    parameter int V_ACTIVE = video_timing_pkg::V_ACTIVE,
    parameter int V_TOTAL  = video_timing_pkg::V_TOTAL
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               pxl_cen,
    output logic [video_timing_pkg::POS_W-1:0] hdump,
    output logic [video_timing_pkg::POS_W-1:0] vdump,
    output logic [video_timing_pkg::POS_W-1:0] vrender,
    output logic                               HS,
    output logic                               VS,
    output logic                               HB,
    output logic                               VB,
    output logic                               line_start
);

    localparam int POS_W = video_timing_pkg::POS_W;

    logic h_last;
    logic v_last;

    assign h_last = hdump == POS_W'(H_TOTAL - 1);
    assign v_last = vdump == POS_W'(V_TOTAL - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump <= '0;
            vdump <= '0;
        end else if (pxl_cen) begin
            if (h_last) begin
                hdump <= '0;
                vdump <= v_last ? '0 : vdump + 1'd1;
            end else begin
                hdump <= hdump + 1'd1;
            end
        end
    end

    // Line being fetched, one ahead of the line on screen
    assign vrender = v_last ? '0 : vdump + 1'd1;

    assign HB = hdump >= POS_W'(H_ACTIVE);
    assign VB = vdump >= POS_W'(V_ACTIVE);
    assign HS = hdump >= POS_W'(video_timing_pkg::HS_START)
             && hdump <  POS_W'(video_timing_pkg::HS_END);
    assign VS = vdump >= POS_W'(video_timing_pkg::VS_START)
             && vdump <  POS_W'(video_timing_pkg::VS_END);

    // One clk wide, on the enable that shows pixel 0
    assign line_start = pxl_cen && hdump == '0;

endmodule

`default_nettype wire

/* verilog/video_mmr.sv */
// Video register block
// CPU-written scroll, control, backdrop and palette, scroll latched per frame
`timescale 1ns/1ns
`default_nettype none

module video_mmr (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 pxl_cen,
    // CPU write port
    input  logic                                 reg_cs,
    input  logic [video_regs_pkg::REG_ADDR_W-1:0] reg_addr,
    input  logic [video_regs_pkg::REG_DATA_W-1:0] reg_data,
    // Raster position
    input  logic [video_timing_pkg::POS_W-1:0]   hdump,
    input  logic [video_timing_pkg::POS_W-1:0]   vdump,
    // Register outputs
    output logic [9:0]                           hscroll,
    output logic [9:0]                           vscroll,
    output logic                                 layer_en,
    output logic [video_regs_pkg::COLOR_W-1:0]   backdrop,
    // Palette read port
    input  logic [video_regs_pkg::PXL_W-1:0]     pal_rd_idx,
    output logic [video_regs_pkg::COLOR_W-1:0]   pal_rd_color
);

    localparam int PXL_W    = video_regs_pkg::PXL_W;
    localparam int COLOR_W  = video_regs_pkg::COLOR_W;
    localparam int PAL_SIZE = 2 ** PXL_W;

    logic [9:0]         hscroll_wr;
    logic [9:0]         vscroll_wr;
    logic               pal_we;
    logic               frame_start;
    logic [COLOR_W-1:0] pal_mem [PAL_SIZE];

    assign pal_we      = reg_cs && reg_addr >= video_regs_pkg::PAL_BASE;
    assign frame_start = pxl_cen && hdump == '0 && vdump == '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hscroll_wr <= '0;
            vscroll_wr <= '0;
            layer_en   <= 1'b0;
            backdrop   <= '0;
        end else if (reg_cs) begin
            case (reg_addr)
                video_regs_pkg::REG_HSCROLL:  hscroll_wr <= reg_data[9:0];
                video_regs_pkg::REG_VSCROLL:  vscroll_wr <= reg_data[9:0];
                video_regs_pkg::REG_CTRL:     layer_en <= reg_data[video_regs_pkg::CTRL_LAYER_EN];
                video_regs_pkg::REG_BACKDROP: backdrop <= reg_data[COLOR_W-1:0];
                default: ;
            endcase
        end
    end

    // Scroll in use only changes at the top of a frame
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hscroll <= '0;
            vscroll <= '0;
        end else if (frame_start) begin
            hscroll <= hscroll_wr;
            vscroll <= vscroll_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_mem[reg_addr[PXL_W-1:0]] <= reg_data[COLOR_W-1:0];
        end
    end

    assign pal_rd_color = pal_mem[pal_rd_idx];

endmodule

`default_nettype wire

/* verilog/tile_scroll.sv */
// Scroll layer
// Fetches one ROM row segment per line into a ping-pong buffer and reads
// it back with the fine horizontal offset
`timescale 1ns/1ns
`default_nettype none

module tile_scroll #(
    parameter int H_ACTIVE = video_timing_pkg::H_ACTIVE
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  pxl_cen,
    input  logic                                  line_start,
    input  logic [video_timing_pkg::POS_W-1:0]    vrender,
    input  logic [video_timing_pkg::POS_W-1:0]    hdump,
    input  logic [9:0]                            hscroll,
    input  logic [9:0]                            vscroll,
    // Graphics ROM
    output logic                                  rom_cs,
    output logic [video_regs_pkg::ROM_ADDR_W-1:0] rom_addr,
    input  logic [video_regs_pkg::ROM_DATA_W-1:0] rom_data,
    input  logic                                  rom_ok,
    output logic [video_regs_pkg::PXL_W-1:0]      pxl_index
);

    localparam int POS_W    = video_timing_pkg::POS_W;
    localparam int PXL_W    = video_regs_pkg::PXL_W;
    localparam int PIX_WORD = video_regs_pkg::ROM_DATA_W / PXL_W;
    // One spare word covers the fine scroll offset
    localparam int LINE_PX  = H_ACTIVE + PIX_WORD;
    localparam int IDX_W    = $clog2(LINE_PX);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        GAP
    } fetch_state_t;

    fetch_state_t     state;
    logic [5:0]       fetch_row;
    logic [2:0]       fetch_col;
    logic [IDX_W-1:0] wr_base;
    logic             front;
    logic             rd_half;
    logic [IDX_W-1:0] rd_pos;
    logic [PXL_W-1:0] line_buf [2][LINE_PX];

    assign rom_cs   = state == REQ;
    assign rom_addr = {fetch_row, fetch_col};

    // Fetch FSM, cs drops for a cycle between words
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            fetch_row <= '0;
            fetch_col <= '0;
            wr_base   <= '0;
            front     <= 1'b0;
        end else if (line_start) begin
            front     <= ~front;
            fetch_row <= vrender[5:0] + vscroll[5:0];
            fetch_col <= hscroll[5:3];
            wr_base   <= '0;
            state     <= REQ;
        end else begin
            case (state)
                REQ: begin
                    if (rom_ok) begin
                        // Column wraps within the 64 pixel bitmap
                        fetch_col <= fetch_col + 1'd1;
                        wr_base   <= wr_base + IDX_W'(PIX_WORD);
                        state     <= wr_base == IDX_W'(LINE_PX - PIX_WORD) ? IDLE : GAP;
                    end
                end
                GAP:     state <= REQ;
                default: state <= IDLE;
            endcase
        end
    end

    // Unpack a ROM word into the back half
    always_ff @(posedge clk) begin
        if (rom_cs && rom_ok) begin
            for (int k = 0; k < PIX_WORD; k++) begin
                line_buf[~front][wr_base + IDX_W'(k)] <= rom_data[k*PXL_W +: PXL_W];
            end
        end
    end

    // Half swapped in by line_start is shown from that same enable
    assign rd_half = front ^ line_start;
    assign rd_pos  = hdump[IDX_W-1:0] + IDX_W'(hscroll[2:0]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl_index <= '0;
        end else if (pxl_cen) begin
            if (hdump < POS_W'(H_ACTIVE)) begin
                pxl_index <= line_buf[rd_half][rd_pos];
            end else begin
                pxl_index <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/video_colmix.sv */
// Colour mixer
// Backdrop for transparent pixels, palette lookup, 4:4:4 to 8:8:8 and blanking
`timescale 1ns/1ns
`default_nettype none

module video_colmix (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               pxl_cen,
    input  logic                               HB,
    input  logic                               VB,
    input  logic                               layer_en,
    input  logic [video_regs_pkg::PXL_W-1:0]   pxl_index,
    input  logic [video_regs_pkg::COLOR_W-1:0] backdrop,
    input  logic [video_regs_pkg::COLOR_W-1:0] pal_rd_color,
    output logic [video_regs_pkg::PXL_W-1:0]   pal_rd_idx,
    output logic [7:0]                         red,
    output logic [7:0]                         green,
    output logic [7:0]                         blue,
    output logic                               LHBL_dly,
    output logic                               LVBL_dly
);

    localparam int CH_W = video_regs_pkg::CH_W;

    logic                               hb_d;
    logic                               vb_d;
    logic [video_regs_pkg::COLOR_W-1:0] color;

    assign pal_rd_idx = pxl_index;
    // Index 0 is transparent
    assign color = (!layer_en || pxl_index == '0) ? backdrop : pal_rd_color;

    // Blanking delayed to meet the layer pixel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hb_d <= 1'b1;
            vb_d <= 1'b1;
        end else if (pxl_cen) begin
            hb_d <= HB;
            vb_d <= VB;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            LHBL_dly <= 1'b0;
            LVBL_dly <= 1'b0;
            red      <= '0;
            green    <= '0;
            blue     <= '0;
        end else if (pxl_cen) begin
            LHBL_dly <= ~hb_d;
            LVBL_dly <= ~vb_d;
            if (hb_d || vb_d) begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end else begin
                // Nibble repeated to fill the 8-bit channel
                red   <= {2{color[3*CH_W-1 -: CH_W]}};
                green <= {2{color[2*CH_W-1 -: CH_W]}};
                blue  <= {2{color[CH_W-1 -: CH_W]}};
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/video_top.sv */
// Video subsystem top level
// Raster timing, CPU registers, one scroll layer and the colour mixer
`timescale 1ns/1ns
`default_nettype none

module video_top #(
    parameter int H_ACTIVE = video_timing_pkg::H_ACTIVE,
    parameter int H_TOTAL  = video_timing_pkg::H_TOTAL,
    parameter int V_ACTIVE = video_timing_pkg::V_ACTIVE,
    parameter int V_TOTAL  = video_timing_pkg::V_TOTAL
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  pxl_cen,
    // CPU write port
    input  logic                                  reg_cs,
    input  logic [video_regs_pkg::REG_ADDR_W-1:0] reg_addr,
    input  logic [video_regs_pkg::REG_DATA_W-1:0] reg_data,
    // Graphics ROM
    output logic                                  rom_cs,
    output logic [video_regs_pkg::ROM_ADDR_W-1:0] rom_addr,
    input  logic [video_regs_pkg::ROM_DATA_W-1:0] rom_data,
    input  logic                                  rom_ok,
    // Video out
    output logic                                  HS,
    output logic                                  VS,
    output logic                                  LHBL_dly,
    output logic                                  LVBL_dly,
    output logic [7:0]                            red,
    output logic [7:0]                            green,
    output logic [7:0]                            blue
);

    logic [video_timing_pkg::POS_W-1:0] hdump;
    logic [video_timing_pkg::POS_W-1:0] vdump;
    logic [video_timing_pkg::POS_W-1:0] vrender;
    logic                               HB;
    logic                               VB;
    logic                               line_start;
    logic [9:0]                         hscroll;
    logic [9:0]                         vscroll;
    logic                               layer_en;
    logic [video_regs_pkg::COLOR_W-1:0] backdrop;
    logic [video_regs_pkg::COLOR_W-1:0] pal_rd_color;
    logic [video_regs_pkg::PXL_W-1:0]   pal_rd_idx;
    logic [video_regs_pkg::PXL_W-1:0]   pxl_index;

    video_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL)
    ) timing_i (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .hdump      (hdump),
        .vdump      (vdump),
        .vrender    (vrender),
        .HS         (HS),
        .VS         (VS),
        .HB         (HB),
        .VB         (VB),
        .line_start (line_start)
    );

    video_mmr mmr_i (
        .clk          (clk),
        .rst          (rst),
        .pxl_cen      (pxl_cen),
        .reg_cs       (reg_cs),
        .reg_addr     (reg_addr),
        .reg_data     (reg_data),
        .hdump        (hdump),
        .vdump        (vdump),
        .hscroll      (hscroll),
        .vscroll      (vscroll),
        .layer_en     (layer_en),
        .backdrop     (backdrop),
        .pal_rd_idx   (pal_rd_idx),
        .pal_rd_color (pal_rd_color)
    );

    tile_scroll #(
        .H_ACTIVE (H_ACTIVE)
    ) scroll_i (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .line_start (line_start),
        .vrender    (vrender),
        .hdump      (hdump),
        .hscroll    (hscroll),
        .vscroll    (vscroll),
        .rom_cs     (rom_cs),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .pxl_index  (pxl_index)
    );

    video_colmix colmix_i (
        .clk          (clk),
        .rst          (rst),
        .pxl_cen      (pxl_cen),
        .HB           (HB),
        .VB           (VB),
        .layer_en     (layer_en),
        .pxl_index    (pxl_index),
        .backdrop     (backdrop),
        .pal_rd_color (pal_rd_color),
        .pal_rd_idx   (pal_rd_idx),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .LHBL_dly     (LHBL_dly),
        .LVBL_dly     (LVBL_dly)
    );

endmodule

`default_nettype wire

/* testbench/video_chk.sv */
// Protocol checker for the video top level
// Sync inside blanking and graphics ROM request rules
`timescale 1ns/1ns
`default_nettype none

module video_chk (
    input logic                                  clk,
    input logic                                  rst,
    input logic                                  HS,
    input logic                                  VS,
    input logic                                  HB,
    input logic                                  VB,
    input logic                                  rom_cs,
    input logic [video_regs_pkg::ROM_ADDR_W-1:0] rom_addr,
    input logic                                  rom_ok
);

    int fail_cnt = 0;

    // Sync pulses sit inside blanking
    hs_in_hblank: assert property (@(posedge clk) disable iff (rst) HS |-> HB)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("HS active outside horizontal blanking");
        end

    vs_in_vblank: assert property (@(posedge clk) disable iff (rst) VS |-> VB)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("VS active outside vertical blanking");
        end

    // Request held with a steady address until the ROM answers
    rom_req_held: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("rom_cs or rom_addr changed before rom_ok");
        end

    rom_ok_with_cs: assert property (@(posedge clk) disable iff (rst) rom_ok |-> rom_cs)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("rom_ok seen without rom_cs");
        end

endmodule

`default_nettype wire

/* testbench/video_tb.sv */
// Video subsystem testbench
// Register writes from a command file, a graphics ROM model with random delay
// and a pixel by pixel check of every output frame
`timescale 1ns/1ns
`default_nettype none

module video_tb;

    localparam int H_ACTIVE  = video_timing_pkg::H_ACTIVE;
    localparam int H_TOTAL   = video_timing_pkg::H_TOTAL;
    localparam int V_ACTIVE  = video_timing_pkg::V_ACTIVE;
    localparam int V_TOTAL   = video_timing_pkg::V_TOTAL;
    localparam int FRAME_PX  = H_TOTAL * V_TOTAL;
    localparam int CMD_DEPTH = 64;

    logic                                  clk = 1'b0;
    logic                                  rst;
    logic                                  pxl_cen = 1'b0;
    logic                                  reg_cs;
    logic [video_regs_pkg::REG_ADDR_W-1:0] reg_addr;
    logic [video_regs_pkg::REG_DATA_W-1:0] reg_data;
    logic                                  rom_cs;
    logic [video_regs_pkg::ROM_ADDR_W-1:0] rom_addr;
    logic [video_regs_pkg::ROM_DATA_W-1:0] rom_data = '0;
    logic                                  rom_ok = 1'b0;
    logic                                  HS;
    logic                                  VS;
    logic                                  LHBL_dly;
    logic                                  LVBL_dly;
    logic [7:0]                            red;
    logic [7:0]                            green;
    logic [7:0]                            blue;

    // Register contents as written by the bench
    logic [11:0] pal_model [16];
    logic [11:0] backdrop_model;
    logic        layer_model;
    logic [9:0]  hscroll_model;
    logic [9:0]  vscroll_model;
    logic        scroll_dirty;

    // Outputs taken at the last sample point
    logic [23:0] smp_rgb;
    logic        smp_hbl;
    logic        smp_vbl;
    logic        smp_hs;
    logic        smp_vs;

    logic [27:0] cmds [CMD_DEPTH];
    int          rom_wait = 0;
    logic        rom_busy = 1'b0;
    int unsigned seed;

    video_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .reg_cs   (reg_cs),
        .reg_addr (reg_addr),
        .reg_data (reg_data),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .HS       (HS),
        .VS       (VS),
        .LHBL_dly (LHBL_dly),
        .LVBL_dly (LVBL_dly),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

    bind video_top video_chk chk_i (
        .clk      (clk),
        .rst      (rst),
        .HS       (HS),
        .VS       (VS),
        .HB       (HB),
        .VB       (VB),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_ok   (rom_ok)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    // Pixel enable on every second cycle
    always @(negedge clk) begin
        pxl_cen <= ~pxl_cen;
    end

    // Nibble k of word a is (a + k) mod 16
    function automatic logic [31:0] rom_word(input logic [8:0] addr);
        logic [31:0] word;
        word = '0;
        for (int k = 0; k < 8; k++) begin
            word[4*k +: 4] = 4'((int'(addr) + k) % 16);
        end
        return word;
    endfunction

    // Graphics ROM, answer comes 0 to 3 cycles after the first cs cycle
    always @(negedge clk) begin
        if (rom_ok) begin
            rom_ok <= 1'b0;
        end else if (rom_cs) begin
            if (!rom_busy) begin
                rom_busy = 1'b1;
                rom_wait = int'($urandom % 4);
            end
            if (rom_wait == 0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_word(rom_addr);
                rom_busy = 1'b0;
            end else begin
                rom_wait = rom_wait - 1;
            end
        end
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                                 input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("mismatch at %0t ns: %s, got %h, expected %h",
                                        $time, what, actual, expected));
        end
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [15:0] data);
        @(negedge clk);
        reg_cs   = 1'b1;
        reg_addr = addr;
        reg_data = data;
        @(negedge clk);
        reg_cs = 1'b0;
        if (addr >= video_regs_pkg::PAL_BASE) begin
            pal_model[addr[3:0]] = data[11:0];
        end else begin
            case (addr)
                video_regs_pkg::REG_HSCROLL: begin
                    hscroll_model = data[9:0];
                    scroll_dirty  = 1'b1;
                end
                video_regs_pkg::REG_VSCROLL: begin
                    vscroll_model = data[9:0];
                    scroll_dirty  = 1'b1;
                end
                video_regs_pkg::REG_CTRL:     layer_model = data[0];
                video_regs_pkg::REG_BACKDROP: backdrop_model = data[11:0];
                default: ;
            endcase
        end
    endtask

    // Entry i gets base + i * 0x173
    task automatic fill_palette(input logic [11:0] base);
        for (int i = 0; i < 16; i++) begin
            write_reg(video_regs_pkg::PAL_BASE + 5'(i), 16'(base + 12'(i * 'h173)));
        end
    endtask

    // Outputs only move on enable edges, so sample on the cycle between them
    task automatic take_sample();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > 4) begin
                stop_with_failure("pixel enable stopped toggling while waiting for a sample");
            end
        end while (pxl_cen);
        smp_rgb = {red, green, blue};
        smp_hbl = LHBL_dly;
        smp_vbl = LVBL_dly;
        smp_hs  = HS;
        smp_vs  = VS;
    endtask

    // Returns with the first pixel of the frame sampled
    task automatic wait_frame_start();
        logic prev;
        int   n;
        take_sample();
        n = 0;
        do begin
            prev = smp_vbl;
            take_sample();
            n++;
            if (n > 2 * FRAME_PX) begin
                stop_with_failure("no rising edge of LVBL_dly within two frames");
            end
        end while (!(smp_vbl && !prev));
    endtask

    function automatic logic [23:0] expected_rgb(input int x, input int y);
        int          xs;
        int          ys;
        int          idx;
        logic [11:0] color;
        xs  = (x + int'(hscroll_model)) % 64;
        ys  = (y + int'(vscroll_model)) % 64;
        // Word {row, column / 8}, nibble column mod 8
        idx = (ys * 8 + xs / 8 + xs % 8) % 16;
        if (!layer_model || idx == 0) begin
            color = backdrop_model;
        end else begin
            color = pal_model[idx];
        end
        return {{2{color[11:8]}}, {2{color[7:4]}}, {2{color[3:0]}}};
    endfunction

    task automatic score_pixel(input int x, input int y);
        logic        vis;
        logic [23:0] exp_rgb;
        int          pos;
        int          hx;
        int          vy;
        logic        exp_hs;
        logic        exp_vs;
        string       where;
        where   = $sformatf("x=%0d y=%0d", x, y);
        vis     = x < H_ACTIVE && y < V_ACTIVE;
        exp_rgb = vis ? expected_rgb(x, y) : 24'h0;
        // Sync is not delayed, so it runs two enables ahead of the pixel
        pos     = (y * H_TOTAL + x + 2) % FRAME_PX;
        hx      = pos % H_TOTAL;
        vy      = pos / H_TOTAL;
        exp_hs  = hx >= video_timing_pkg::HS_START && hx < video_timing_pkg::HS_END;
        exp_vs  = vy >= video_timing_pkg::VS_START && vy < video_timing_pkg::VS_END;
        compare_value(32'(smp_hbl), 32'(x < H_ACTIVE), {"LHBL_dly at ", where});
        compare_value(32'(smp_vbl), 32'(y < V_ACTIVE), {"LVBL_dly at ", where});
        compare_value(32'(smp_hs), 32'(exp_hs), {"HS at ", where});
        compare_value(32'(smp_vs), 32'(exp_vs), {"VS at ", where});
        compare_value(32'(smp_rgb), 32'(exp_rgb), {"colour at ", where});
    endtask

    task automatic run_frame_check(input int nframes);
        // Scroll is latched at frame start, let two frames settle
        repeat (scroll_dirty ? 2 : 0) wait_frame_start();
        scroll_dirty = 1'b0;
        wait_frame_start();
        for (int f = 0; f < nframes; f++) begin
            for (int y = 0; y < V_TOTAL; y++) begin
                for (int x = 0; x < H_TOTAL; x++) begin
                    if (f != 0 || y != 0 || x != 0) begin
                        take_sample();
                    end
                    score_pixel(x, y);
                end
            end
        end
    endtask

    initial begin
        int idx;
        seed           = $urandom(32'h547);
        rst            = 1'b1;
        reg_cs         = 1'b0;
        reg_addr       = '0;
        reg_data       = '0;
        backdrop_model = '0;
        layer_model    = 1'b0;
        hscroll_model  = '0;
        vscroll_model  = '0;
        scroll_dirty   = 1'b0;
        foreach (pal_model[i]) begin
            pal_model[i] = '0;
        end
        foreach (cmds[i]) begin
            cmds[i] = '0;
        end
        $readmemh("testbench/video_input.txt", cmds);
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // Op in the top nibble, zero ends the list
        idx = 0;
        while (idx < CMD_DEPTH && cmds[idx][27:24] != 4'h0) begin
            case (cmds[idx][27:24])
                4'h1:    write_reg(cmds[idx][20:16], cmds[idx][15:0]);
                4'h2:    run_frame_check(int'(cmds[idx][15:0]));
                4'h3:    fill_palette(cmds[idx][11:0]);
                default: stop_with_failure("unknown command in the input file");
            endcase
            idx++;
        end

        if (dut_i.chk_i.fail_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("%0d protocol assertion failures", dut_i.chk_i.fail_cnt);
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/video_input.txt */
// Video test commands, one hex word per line as op_addr_data
// op 1 writes data to register addr, op 2 checks data frames, op 3 fills the palette
2_00_0001 // reset state
1_03_0a5f // backdrop, layer still off
2_00_0001
3_00_0123
1_02_0001 // layer on, zero scroll
2_00_0002
1_00_00fd // hscroll 61 after mod 64
2_00_0001
1_00_0013
1_01_0025
2_00_0002
1_01_003f // rows wrap
2_00_0001
3_00_0e41 // palette rewrite
2_00_0002
1_02_8000 // layer off, reserved bit set
2_00_0001

/* flist.f */
verilog/video_timing_pkg.sv
verilog/video_regs_pkg.sv
verilog/video_timing.sv
verilog/video_mmr.sv
verilog/tile_scroll.sv
verilog/video_colmix.sv
verilog/video_top.sv
testbench/video_chk.sv
testbench/video_tb.sv

/* Makefile */
# Verilator simulation of the video subsystem

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal -f flist.f --top-module video_tb
	./obj_dir/Vvideo_tb | awk '{ print } /Done: no errors/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
